//--- rtl/lc4_defines.svh
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// datapath widths
`define LC4_WORD_W     16
`define LC4_REG_SEL_W  3
`define LC4_NUM_REGS   8

// issue width, two register reads per lane
`define LC4_NUM_LANES  2
`define LC4_NUM_RD     (2 * `LC4_NUM_LANES)

// first fetch address out of reset
`define LC4_RESET_PC   16'h8200

// major opcodes, insn[15:12]
`define LC4_OP_NOP     4'b0000
`define LC4_OP_ARITH   4'b0001
`define LC4_OP_LOGIC   4'b0101
`define LC4_OP_CONST   4'b1001

// sub-operation codes, insn[5:3]
`define LC4_ARITH_ADD  3'b000
`define LC4_ARITH_SUB  3'b010
`define LC4_LOGIC_AND  3'b000
`define LC4_LOGIC_OR   3'b010
`define LC4_LOGIC_XOR  3'b011

`endif

//--- rtl/lc4_pkg.sv
`include "lc4_defines.svh"

package lc4_pkg;

   typedef logic [`LC4_WORD_W-1:0]    word_t;
   typedef logic [`LC4_WORD_W-1:0]    insn_t;
   typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;

   // stall code seen on the retire trace
   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_SPLIT = 2'd1,
      STALL_EMPTY = 2'd2
   } stall_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM,
      ALU_NONE
   } alu_op_t;

   typedef struct packed {
      reg_sel_t rs;
      logic     rs_re;
      reg_sel_t rt;
      logic     rt_re;
      reg_sel_t rd;
      logic     rd_we;
      alu_op_t  alu_op;
      logic     use_imm;
   } decode_t;

   // one instruction leaving D for a lane
   typedef struct packed {
      word_t   pc;
      insn_t   insn;
      decode_t dec;
      word_t   rs_val;
      word_t   rt_val;
      word_t   imm;
      stall_t  stall;
   } issue_t;

   typedef struct packed {
      logic     we;
      reg_sel_t rd;
      word_t    data;
   } bypass_t;

   typedef struct packed {
      word_t    pc;
      insn_t    insn;
      logic     we;
      reg_sel_t wsel;
      word_t    data;
      stall_t   stall;
   } retire_t;

   function automatic decode_t lc4_decode(input insn_t insn, output word_t imm);
      decode_t dec;
      dec        = '0;
      dec.alu_op = ALU_NONE;
      imm        = '0;
      dec.rd     = insn[11:9];
      dec.rs     = insn[8:6];
      dec.rt     = insn[2:0];
      case (insn[15:12])
         `LC4_OP_NOP: begin
            // stays a no-write instruction
            dec.rd = '0;
         end
         `LC4_OP_ARITH: begin
            if (insn[5]) begin
               imm         = {{(`LC4_WORD_W-5){insn[4]}}, insn[4:0]};
               dec.use_imm = 1'b1;
               dec.alu_op  = ALU_ADD;
            end else begin
               case (insn[5:3])
                  `LC4_ARITH_ADD: dec.alu_op = ALU_ADD;
                  `LC4_ARITH_SUB: dec.alu_op = ALU_SUB;
                  default:        dec.alu_op = ALU_NONE;
               endcase
            end
         end
         `LC4_OP_LOGIC: begin
            case (insn[5:3])
               `LC4_LOGIC_AND: dec.alu_op = ALU_AND;
               `LC4_LOGIC_OR:  dec.alu_op = ALU_OR;
               `LC4_LOGIC_XOR: dec.alu_op = ALU_XOR;
               default:        dec.alu_op = ALU_NONE;
            endcase
         end
         `LC4_OP_CONST: begin
            imm         = {{(`LC4_WORD_W-9){insn[8]}}, insn[8:0]};
            dec.use_imm = 1'b1;
            dec.alu_op  = ALU_PASS_IMM;
         end
         default: dec.alu_op = ALU_NONE;
      endcase
      // only the kept operations write or read registers
      dec.rd_we = (dec.alu_op != ALU_NONE);
      dec.rs_re = dec.rd_we && (dec.alu_op != ALU_PASS_IMM);
      dec.rt_re = dec.rs_re && !dec.use_imm;
      return dec;
   endfunction

endpackage

//--- rtl/lc4_issue.sv
`timescale 1ns/10ps
`include "lc4_defines.svh"

module lc4_issue (
   input  logic              gwe,
   input  logic              i_rst,
   input  lc4_pkg::insn_t    i_insn [`LC4_NUM_LANES],
   output lc4_pkg::word_t    o_cur_pc,
   output lc4_pkg::reg_sel_t o_rd_sel [`LC4_NUM_RD],
   input  lc4_pkg::word_t    i_rd_data [`LC4_NUM_RD],
   output lc4_pkg::issue_t   o_issue [`LC4_NUM_LANES]
);
   import lc4_pkg::*;

   // one decode slot, empty marks a reset bubble
   typedef struct packed {
      word_t pc;
      insn_t insn;
      logic  empty;
   } slot_t;

   word_t   pc_q;
   word_t   pc_plus_one;
   word_t   pc_plus_two;
   slot_t   slot_a_q;
   slot_t   slot_b_q;
   decode_t dec_a;
   decode_t dec_b;
   word_t   imm_a;
   word_t   imm_b;
   logic    split;

   function automatic issue_t build_issue(slot_t s, decode_t d, word_t imm,
                                          word_t rs_val, word_t rt_val);
      issue_t p;
      p = '0;
      if (s.empty) begin
         p.stall = STALL_EMPTY;
      end else begin
         p.pc     = s.pc;
         p.insn   = s.insn;
         p.dec    = d;
         p.rs_val = rs_val;
         p.rt_val = rt_val;
         p.imm    = imm;
         p.stall  = STALL_NONE;
      end
      return p;
   endfunction

   assign pc_plus_one = pc_q + word_t'(1);
   assign pc_plus_two = pc_q + word_t'(2);
   assign o_cur_pc    = pc_q;

   always_comb begin
      dec_a = lc4_decode(slot_a_q.insn, imm_a);
      dec_b = lc4_decode(slot_b_q.insn, imm_b);
   end

   // B is held back when it reads what A writes in the same pair
   always_comb begin
      split = !slot_a_q.empty && !slot_b_q.empty && dec_a.rd_we &&
              ((dec_b.rs_re && (dec_b.rs == dec_a.rd)) ||
               (dec_b.rt_re && (dec_b.rt == dec_a.rd)));
   end

   // read ports: A.rs, A.rt, B.rs, B.rt
   assign o_rd_sel[0] = dec_a.rs;
   assign o_rd_sel[1] = dec_a.rt;
   assign o_rd_sel[2] = dec_b.rs;
   assign o_rd_sel[3] = dec_b.rt;

   always_comb begin
      o_issue[0] = build_issue(slot_a_q, dec_a, imm_a, i_rd_data[0], i_rd_data[1]);
      if (split) begin
         o_issue[1]       = '0;
         o_issue[1].stall = STALL_SPLIT;
      end else begin
         o_issue[1] = build_issue(slot_b_q, dec_b, imm_b, i_rd_data[2], i_rd_data[3]);
      end
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc_q     <= `LC4_RESET_PC;
         slot_a_q <= '{pc: '0, insn: '0, empty: 1'b1};
         slot_b_q <= '{pc: '0, insn: '0, empty: 1'b1};
      end else if (split) begin
         // B moves up to A, the next fetched word fills B
         pc_q     <= pc_plus_one;
         slot_a_q <= slot_b_q;
         slot_b_q <= '{pc: pc_q, insn: i_insn[0], empty: 1'b0};
      end else begin
         pc_q     <= pc_plus_two;
         slot_a_q <= '{pc: pc_q, insn: i_insn[0], empty: 1'b0};
         slot_b_q <= '{pc: pc_plus_one, insn: i_insn[1], empty: 1'b0};
      end
   end

   // fetch moves forward by one on a split and by two otherwise
   a_pc_step: assert property (@(posedge gwe) disable iff (i_rst)
      !$past(i_rst) |->
         (pc_q == $past(pc_q) + word_t'(1)) || (pc_q == $past(pc_q) + word_t'(2)));

endmodule

//--- rtl/lc4_exec_lane.sv
`timescale 1ns/10ps
`include "lc4_defines.svh"

module lc4_exec_lane (
   input  logic             gwe,
   input  logic             i_rst,
   input  lc4_pkg::issue_t  i_issue,
   input  lc4_pkg::bypass_t i_bypass [`LC4_NUM_LANES],
   output lc4_pkg::bypass_t o_bypass,
   output lc4_pkg::retire_t o_retire
);
   import lc4_pkg::*;

   issue_t  x_q;
   retire_t w_q;
   word_t   op_a;
   word_t   op_rt;
   word_t   op_b;
   word_t   alu_out;

   // W of every lane, higher lane is younger and wins
   function automatic word_t wb_bypass(reg_sel_t sel, word_t reg_val);
      word_t v;
      v = reg_val;
      for (int l = 0; l < `LC4_NUM_LANES; l++) begin
         if (i_bypass[l].we && (i_bypass[l].rd == sel)) begin
            v = i_bypass[l].data;
         end
      end
      return v;
   endfunction

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         x_q       <= '0;
         x_q.stall <= STALL_EMPTY;
      end else begin
         x_q <= i_issue;
      end
   end

   always_comb begin
      op_a  = wb_bypass(x_q.dec.rs, x_q.rs_val);
      op_rt = wb_bypass(x_q.dec.rt, x_q.rt_val);
   end

   assign op_b = x_q.dec.use_imm ? x_q.imm : op_rt;

   always_comb begin
      case (x_q.dec.alu_op)
         ALU_ADD:      alu_out = op_a + op_b;
         ALU_SUB:      alu_out = op_a - op_b;
         ALU_AND:      alu_out = op_a & op_b;
         ALU_OR:       alu_out = op_a | op_b;
         ALU_XOR:      alu_out = op_a ^ op_b;
         ALU_PASS_IMM: alu_out = x_q.imm;
         default:      alu_out = '0;
      endcase
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         w_q <= '{pc: '0, insn: '0, we: 1'b0, wsel: '0, data: '0, stall: STALL_EMPTY};
      end else begin
         w_q.pc    <= x_q.pc;
         w_q.insn  <= x_q.insn;
         w_q.we    <= x_q.dec.rd_we;
         w_q.wsel  <= x_q.dec.rd;
         w_q.data  <= alu_out;
         w_q.stall <= x_q.stall;
      end
   end

   assign o_bypass = '{we: w_q.we, rd: w_q.wsel, data: w_q.data};
   assign o_retire = w_q;

   // bubbles from the issue stage never carry a write
   a_we_no_stall: assert property (@(posedge gwe) disable iff (i_rst)
      w_q.we |-> (w_q.stall == STALL_NONE));

endmodule

//--- rtl/lc4_regfile_wb.sv
`timescale 1ns/10ps
`include "lc4_defines.svh"

module lc4_regfile_wb (
   input  logic              gwe,
   input  logic              i_rst,
   input  lc4_pkg::reg_sel_t i_rd_sel [`LC4_NUM_RD],
   output lc4_pkg::word_t    o_rd_data [`LC4_NUM_RD],
   input  lc4_pkg::retire_t  i_retire [`LC4_NUM_LANES],
   output lc4_pkg::retire_t  o_retire [`LC4_NUM_LANES]
);
   import lc4_pkg::*;

   word_t                     regs [`LC4_NUM_REGS];
   logic [`LC4_NUM_LANES-1:0] wr_en;

   always_comb begin
      for (int l = 0; l < `LC4_NUM_LANES; l++) begin
         wr_en[l] = i_retire[l].we;
      end
   end

   // lane 1 is written last so it wins on a shared register
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int r = 0; r < `LC4_NUM_REGS; r++) begin
            regs[r] <= '0;
         end
      end else begin
         for (int l = 0; l < `LC4_NUM_LANES; l++) begin
            if (wr_en[l]) begin
               regs[i_retire[l].wsel] <= i_retire[l].data;
            end
         end
      end
   end

   // write-through so D sees the value retiring this cycle
   always_comb begin
      for (int p = 0; p < `LC4_NUM_RD; p++) begin
         o_rd_data[p] = regs[i_rd_sel[p]];
         for (int l = 0; l < `LC4_NUM_LANES; l++) begin
            if (wr_en[l] && (i_retire[l].wsel == i_rd_sel[p])) begin
               o_rd_data[p] = i_retire[l].data;
            end
         end
      end
   end

   assign o_retire = i_retire;

   // lanes hold their reset bubbles for as long as reset is held
   a_no_write_in_reset: assert property (@(posedge gwe)
      (i_rst && $past(i_rst)) |-> (wr_en == '0));

endmodule

//--- rtl/lc4_superscalar.sv
`timescale 1ns/10ps
`include "lc4_defines.svh"

module lc4_superscalar (
   input  logic             gwe,
   input  logic             i_rst,
   output lc4_pkg::word_t   o_cur_pc,
   input  lc4_pkg::insn_t   i_insn [`LC4_NUM_LANES],
   output lc4_pkg::retire_t o_retire [`LC4_NUM_LANES]
);
   import lc4_pkg::*;

   reg_sel_t rd_sel  [`LC4_NUM_RD];
   word_t    rd_data [`LC4_NUM_RD];
   issue_t   issue   [`LC4_NUM_LANES];
   bypass_t  bypass  [`LC4_NUM_LANES];
   retire_t  retire  [`LC4_NUM_LANES];

   // fetch and D stage
   lc4_issue u_issue (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_insn    (i_insn),
      .o_cur_pc  (o_cur_pc),
      .o_rd_sel  (rd_sel),
      .i_rd_data (rd_data),
      .o_issue   (issue)
   );

   // X and W, every lane sees the W bypass of all lanes
   for (genvar l = 0; l < `LC4_NUM_LANES; l++) begin : g_lane
      lc4_exec_lane u_lane (
         .gwe      (gwe),
         .i_rst    (i_rst),
         .i_issue  (issue[l]),
         .i_bypass (bypass),
         .o_bypass (bypass[l]),
         .o_retire (retire[l])
      );
   end

   lc4_regfile_wb u_regfile (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_rd_sel  (rd_sel),
      .o_rd_data (rd_data),
      .i_retire  (retire),
      .o_retire  (o_retire)
   );

endmodule

//--- tb/tb_lc4_ref.svh
`ifndef TB_LC4_REF_SVH
`define TB_LC4_REF_SVH

// 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state;
word_t       model_regs [`LC4_NUM_REGS];

function automatic logic lfsr_bit();
   logic fb;
   fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
   lfsr_state = {lfsr_state[14:0], fb};
   return fb;
endfunction

function automatic logic [15:0] rand_bits(input int n);
   logic [15:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_bit()};
   end
   return v;
endfunction

// half the picks land on r0 or r1 so pairs often depend on each other
function automatic reg_sel_t pick_reg();
   logic [15:0] v;
   if (lfsr_bit()) begin
      v = rand_bits(1);
   end else begin
      v = rand_bits(3);
   end
   return v[2:0];
endfunction

function automatic insn_t gen_insn();
   logic [15:0] kind;
   logic [15:0] imm;
   reg_sel_t    rd;
   reg_sel_t    rs;
   reg_sel_t    rt;
   insn_t       insn;
   kind = rand_bits(3);
   rd   = pick_reg();
   rs   = pick_reg();
   rt   = pick_reg();
   imm  = rand_bits(9);
   case (kind[2:0])
      3'd0:    insn = {`LC4_OP_ARITH, rd, rs, `LC4_ARITH_ADD, rt};
      3'd1:    insn = {`LC4_OP_ARITH, rd, rs, `LC4_ARITH_SUB, rt};
      3'd2:    insn = {`LC4_OP_ARITH, rd, rs, 1'b1, imm[4:0]};
      3'd3:    insn = {`LC4_OP_LOGIC, rd, rs, `LC4_LOGIC_AND, rt};
      3'd4:    insn = {`LC4_OP_LOGIC, rd, rs, `LC4_LOGIC_OR, rt};
      3'd5:    insn = {`LC4_OP_LOGIC, rd, rs, `LC4_LOGIC_XOR, rt};
      3'd6:    insn = {`LC4_OP_CONST, rd, imm[8:0]};
      default: insn = {`LC4_OP_NOP, imm[8:0], rt};
   endcase
   return insn;
endfunction

function automatic logic writes_reg(input insn_t insn);
   logic w;
   case (insn[15:12])
      `LC4_OP_ARITH: w = insn[5] || (insn[5:3] == `LC4_ARITH_ADD) ||
                         (insn[5:3] == `LC4_ARITH_SUB);
      `LC4_OP_LOGIC: w = insn[5:3] inside {`LC4_LOGIC_AND, `LC4_LOGIC_OR, `LC4_LOGIC_XOR};
      `LC4_OP_CONST: w = 1'b1;
      default:       w = 1'b0;
   endcase
   return w;
endfunction

// pairing rule: b is held back when it reads the register a writes
function automatic logic splits(input insn_t a, input insn_t b);
   logic rs_read;
   logic rt_read;
   rs_read = writes_reg(b) && (b[15:12] != `LC4_OP_CONST);
   rt_read = rs_read && !((b[15:12] == `LC4_OP_ARITH) && b[5]);
   return writes_reg(a) && ((rs_read && (b[8:6] == a[11:9])) ||
                            (rt_read && (b[2:0] == a[11:9])));
endfunction

// runs one instruction on the model registers and returns its write enable
function automatic logic ref_exec(input insn_t insn, output reg_sel_t wsel,
                                  output word_t data);
   word_t a;
   word_t b;
   a    = model_regs[insn[8:6]];
   b    = insn[5] ? {{11{insn[4]}}, insn[4:0]} : model_regs[insn[2:0]];
   wsel = insn[11:9];
   case (insn[15:12])
      `LC4_OP_ARITH: data = (insn[5:3] == `LC4_ARITH_SUB) ? a - b : a + b;
      `LC4_OP_LOGIC: begin
         case (insn[5:3])
            `LC4_LOGIC_AND: data = a & b;
            `LC4_LOGIC_OR:  data = a | b;
            default:        data = a ^ b;
         endcase
      end
      `LC4_OP_CONST: data = {{7{insn[8]}}, insn[8:0]};
      default:       data = '0;
   endcase
   if (writes_reg(insn)) begin
      model_regs[wsel] = data;
   end
   return writes_reg(insn);
endfunction

`endif

//--- tb/tb_lc4_superscalar.sv
`timescale 1ns/10ps
`include "lc4_defines.svh"

module tb_lc4_superscalar;
   import lc4_pkg::*;

   localparam int    PROG_LEN       = 200;
   localparam int    TIMEOUT_CYCLES = 600;
   localparam int    DRIVE_DLY      = 2;
   // empty retires between reset release and the first pair
   localparam int    FILL_CYCLES    = 3;
   localparam word_t LAST_PC        = `LC4_RESET_PC + word_t'(PROG_LEN - 1);

   logic    gwe = 1'b0;
   logic    i_rst;
   word_t   cur_pc;
   insn_t   insn_bus [`LC4_NUM_LANES];
   retire_t retire   [`LC4_NUM_LANES];
   insn_t   prog     [PROG_LEN];

   word_t   stream_pc;
   int      empty_cycles;
   logic    started;
   logic    last_retired;
   int      checked;
   int      value_errors;
   int      other_errors;

   `include "tb_lc4_ref.svh"

   lc4_superscalar u_dut (
      .gwe      (gwe),
      .i_rst    (i_rst),
      .o_cur_pc (cur_pc),
      .i_insn   (insn_bus),
      .o_retire (retire)
   );

   always #20 gwe = ~gwe;

   // addresses outside the program read as NOP
   function automatic insn_t imem_read(input word_t pc);
      int    idx;
      insn_t insn;
      idx = int'(pc - `LC4_RESET_PC);
      if (idx >= 0 && idx < PROG_LEN) begin
         insn = prog[idx];
      end else begin
         insn = '0;
      end
      return insn;
   endfunction

   function automatic logic in_prog(input word_t pc);
      int idx;
      idx = int'(pc - `LC4_RESET_PC);
      return (idx >= 0) && (idx < PROG_LEN);
   endfunction

   always_comb begin
      insn_bus[0] = imem_read(cur_pc);
      insn_bus[1] = imem_read(cur_pc + word_t'(1));
   end

   task automatic word_eq(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic sel_eq(input string name, input reg_sel_t exp, input reg_sel_t act);
      if (exp !== act) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic stall_eq(input string name, input stall_t exp, input stall_t act);
      if (exp !== act) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic bit_eq(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic lane_check(input int l, input word_t pc, input insn_t insn, input logic we,
                             input reg_sel_t wsel, input word_t data, input stall_t stall);
      string p;
      p = $sformatf("o_retire[%0d]", l);
      stall_eq({p, ".stall"}, stall, retire[l].stall);
      bit_eq({p, ".we"}, we, retire[l].we);
      if (stall == STALL_NONE) begin
         word_eq({p, ".pc"}, pc, retire[l].pc);
         word_eq({p, ".insn"}, insn, retire[l].insn);
      end
      // select and data only mean something on a write
      if (we) begin
         sel_eq({p, ".wsel"}, wsel, retire[l].wsel);
         word_eq({p, ".data"}, data, retire[l].data);
      end
   endtask

   task automatic empty_check();
      for (int l = 0; l < `LC4_NUM_LANES; l++) begin
         lane_check(l, '0, '0, 1'b0, '0, '0, STALL_EMPTY);
      end
   endtask

   // next pair from the unissued stream with lane 0 checked before lane 1
   task automatic pair_check();
      insn_t    a;
      insn_t    b;
      reg_sel_t sel;
      word_t    data;
      logic     we;
      a  = imem_read(stream_pc);
      b  = imem_read(stream_pc + word_t'(1));
      we = ref_exec(a, sel, data);
      lane_check(0, stream_pc, a, we, sel, data, STALL_NONE);
      if (in_prog(stream_pc)) begin
         checked++;
      end
      if (splits(a, b)) begin
         lane_check(1, '0, '0, 1'b0, '0, '0, STALL_SPLIT);
         stream_pc = stream_pc + word_t'(1);
      end else begin
         we = ref_exec(b, sel, data);
         lane_check(1, stream_pc + word_t'(1), b, we, sel, data, STALL_NONE);
         if (in_prog(stream_pc + word_t'(1))) begin
            checked++;
         end
         stream_pc = stream_pc + word_t'(2);
      end
   endtask

   // outputs settle after the rising edge and are sampled on the falling edge
   always @(negedge gwe) begin
      if (i_rst) begin
         word_eq("o_cur_pc", `LC4_RESET_PC, cur_pc);
         empty_check();
      end else if (!started && retire[0].stall == STALL_EMPTY &&
                   retire[1].stall == STALL_EMPTY) begin
         empty_cycles++;
         empty_check();
         if (empty_cycles == 1) begin
            word_eq("o_cur_pc", `LC4_RESET_PC, cur_pc);
         end
      end else begin
         if (!started && empty_cycles != FILL_CYCLES) begin
            $display("first pair retired after %0d empty cycles instead of %0d",
                     empty_cycles, FILL_CYCLES);
            other_errors++;
         end
         started = 1'b1;
         pair_check();
         for (int l = 0; l < `LC4_NUM_LANES; l++) begin
            if (retire[l].stall == STALL_NONE && retire[l].pc == LAST_PC) begin
               last_retired = 1'b1;
            end
         end
      end
   end

   initial begin
      int cycles;
      i_rst        = 1'b1;
      lfsr_state   = 16'd36799;
      stream_pc    = `LC4_RESET_PC;
      empty_cycles = 0;
      started      = 1'b0;
      last_retired = 1'b0;
      checked      = 0;
      value_errors = 0;
      other_errors = 0;
      for (int r = 0; r < `LC4_NUM_REGS; r++) begin
         model_regs[r] = '0;
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         prog[i] = gen_insn();
      end

      repeat (3) @(posedge gwe);
      #DRIVE_DLY i_rst = 1'b0;

      cycles = 0;
      while (!last_retired && cycles < TIMEOUT_CYCLES) begin
         @(posedge gwe);
         cycles++;
      end
      if (!last_retired) begin
         $display("timeout: instruction at 0x%h did not retire within %0d cycles",
                  LAST_PC, TIMEOUT_CYCLES);
         other_errors++;
      end
      if (checked != PROG_LEN) begin
         $display("only %0d of %0d program instructions were checked", checked, PROG_LEN);
         other_errors++;
      end

      $display("checked %0d instructions, value errors %0d, other errors %0d",
               checked, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
+incdir+rtl
+incdir+tb
rtl/lc4_pkg.sv
rtl/lc4_issue.sv
rtl/lc4_exec_lane.sv
rtl/lc4_regfile_wb.sv
rtl/lc4_superscalar.sv
tb/tb_lc4_superscalar.sv

//--- run.sh
#!/bin/sh
# compile and run the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_lc4_superscalar \
   -f build.f -o tb_lc4_superscalar
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/tb_lc4_superscalar)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
